//--- mips_pkg.sv
package mips_pkg;

	//////////////////////////////////////////////////
	// memory sizes
	//////////////////////////////////////////////////

	// instruction store, word addressed
	localparam int IMEM_DEPTH = 32;
	localparam int IMEM_AW = 5;

	// data store, word addressed
	localparam int DMEM_DEPTH = 16;
	localparam int DMEM_AW = $clog2(DMEM_DEPTH);

	//////////////////////////////////////////////////
	// instruction encodings
	//////////////////////////////////////////////////

	// primary opcode field, bits 31:26
	typedef enum logic [5:0]
	{
		op_rtype = 6'b000000,
		op_j     = 6'b000010,
		op_beq   = 6'b000100,
		op_bne   = 6'b000101,
		op_addiu = 6'b001001,
		op_andi  = 6'b001100,
		op_ori   = 6'b001101,
		op_lui   = 6'b001111,
		op_lw    = 6'b100011,
		op_sw    = 6'b101011
	} opcode_e;

	// funct field for r-type, bits 5:0
	typedef enum logic [5:0]
	{
		fn_addu = 6'b100001,
		fn_subu = 6'b100011,
		fn_and  = 6'b100100,
		fn_or   = 6'b100101,
		fn_slt  = 6'b101010
	} funct_e;

	//////////////////////////////////////////////////
	// internal control codes
	//////////////////////////////////////////////////

	// alu operation picked by decode
	typedef enum logic [2:0]
	{
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_lui
	} alu_op_e;

	// writeback source
	typedef enum logic
	{
		res_alu,
		res_load
	} result_sel_e;

endpackage

//--- instr_mem.sv
module instr_mem
(
	input  logic                        clk,
	input  logic [mips_pkg::IMEM_AW-1:0] pc_index,
	output logic [31:0]                  instr,
	input  logic                        prog_we,
	input  logic [mips_pkg::IMEM_AW-1:0] prog_addr,
	input  logic [31:0]                  prog_data
);

	import mips_pkg::*;

	//////////////////////////////////////////////////
	// program storage
	//////////////////////////////////////////////////

	// one word per instruction
	// no reset, contents come from the load port
	logic [31:0] mem [IMEM_DEPTH];

	// program load
	// only used while the core is stopped
	always_ff @(posedge clk)
	begin
		if (prog_we)
		begin
			mem[prog_addr] <= prog_data;
		end
	end

	//////////////////////////////////////////////////
	// fetch
	//////////////////////////////////////////////////

	// combinational read by word index
	// instruction valid in the same cycle as pc
	always_comb
	begin
		instr = mem[pc_index];
	end

endmodule

//--- instr_decode.sv
module instr_decode
(
	input  logic [31:0]                  instr,
	input  logic                         run,
	output logic [4:0]                   rs_addr,
	output logic [4:0]                   rt_addr,
	output logic [4:0]                   wb_addr,
	output logic [31:0]                  imm_ext,
	output logic [mips_pkg::IMEM_AW-1:0] jump_index,
	output mips_pkg::alu_op_e            alu_op,
	output logic                         alu_use_imm,
	output logic                         reg_write,
	output logic                         mem_write,
	output mips_pkg::result_sel_e        result_sel,
	output logic                         branch_eq,
	output logic                         branch_ne,
	output logic                         jump
);

	import mips_pkg::*;

	opcode_e opcode;
	funct_e  funct;
	logic [4:0] rd_addr;
	// raw controls before run and r0 gating
	logic wr_raw;
	logic st_raw;
	logic dest_rt;
	logic sign_ext;

	//////////////////////////////////////////////////
	// field split
	//////////////////////////////////////////////////

	assign opcode = opcode_e'(instr[31:26]);
	assign funct = funct_e'(instr[5:0]);
	assign rs_addr = instr[25:21];
	assign rt_addr = instr[20:16];
	assign rd_addr = instr[15:11];
	// j target, low bits are the word index
	assign jump_index = instr[IMEM_AW-1:0];

	//////////////////////////////////////////////////
	// control decode
	//////////////////////////////////////////////////

	always_comb
	begin
		// defaults give a no-op
		alu_op = alu_add;
		alu_use_imm = 1'b0;
		wr_raw = 1'b0;
		st_raw = 1'b0;
		result_sel = res_alu;
		branch_eq = 1'b0;
		branch_ne = 1'b0;
		jump = 1'b0;
		dest_rt = 1'b1;
		sign_ext = 1'b1;
		case (opcode)
			op_rtype:
			begin
				dest_rt = 1'b0;
				wr_raw = 1'b1;
				case (funct)
					fn_addu: alu_op = alu_add;
					fn_subu: alu_op = alu_sub;
					fn_and:  alu_op = alu_and;
					fn_or:   alu_op = alu_or;
					fn_slt:  alu_op = alu_slt;
					// unknown funct writes nothing
					default: wr_raw = 1'b0;
				endcase
			end
			op_addiu:
			begin
				alu_use_imm = 1'b1;
				wr_raw = 1'b1;
			end
			op_andi:
			begin
				alu_op = alu_and;
				alu_use_imm = 1'b1;
				sign_ext = 1'b0;
				wr_raw = 1'b1;
			end
			op_ori:
			begin
				alu_op = alu_or;
				alu_use_imm = 1'b1;
				sign_ext = 1'b0;
				wr_raw = 1'b1;
			end
			op_lui:
			begin
				alu_op = alu_lui;
				alu_use_imm = 1'b1;
				wr_raw = 1'b1;
			end
			// address is rs plus offset
			op_lw:
			begin
				alu_use_imm = 1'b1;
				result_sel = res_load;
				wr_raw = 1'b1;
			end
			op_sw:
			begin
				alu_use_imm = 1'b1;
				st_raw = 1'b1;
			end
			op_beq: branch_eq = 1'b1;
			op_bne: branch_ne = 1'b1;
			op_j:   jump = 1'b1;
			default: jump = 1'b0;
		endcase
	end

	// immediate extension
	assign imm_ext = sign_ext ? {{16{instr[15]}}, instr[15:0]} : {16'b0, instr[15:0]};

	// rd for r-type, rt otherwise
	assign wb_addr = dest_rt ? rt_addr : rd_addr;

	// r0 never written, nothing retires while stopped
	assign reg_write = run & wr_raw & (wb_addr != 5'd0);
	assign mem_write = run & st_raw;

endmodule

//--- reg_file.sv
module reg_file
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic [4:0]  rs_addr,
	input  logic [4:0]  rt_addr,
	output logic [31:0] rs_data,
	output logic [31:0] rt_data,
	input  logic        wr_en,
	input  logic [4:0]  wr_addr,
	input  logic [31:0] wr_data
);

	// r1..r31, r0 has no storage
	logic [31:0] regs [1:31];

	//////////////////////////////////////////////////
	// write port
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 1; i < 32; i++)
			begin
				regs[i] <= 32'd0;
			end
		end
		else if (wr_en && (wr_addr != 5'd0))
		begin
			regs[wr_addr] <= wr_data;
		end
	end

	//////////////////////////////////////////////////
	// read ports
	//////////////////////////////////////////////////

	// combinational, r0 reads as zero
	// no bypass, write lands at the edge
	assign rs_data = (rs_addr == 5'd0) ? 32'd0 : regs[rs_addr];
	assign rt_data = (rt_addr == 5'd0) ? 32'd0 : regs[rt_addr];

endmodule

//--- alu_execute.sv
module alu_execute
(
	input  logic [31:0]       rs_data,
	input  logic [31:0]       rt_data,
	input  logic [31:0]       imm_ext,
	input  mips_pkg::alu_op_e alu_op,
	input  logic              alu_use_imm,
	output logic [31:0]       alu_result,
	output logic              zero
);

	import mips_pkg::*;

	// second operand
	logic [31:0] op_b;
	// signed compare for slt
	logic lt;

	//////////////////////////////////////////////////
	// operand select
	//////////////////////////////////////////////////

	// immediate forms and memory offsets use imm_ext
	assign op_b = alu_use_imm ? imm_ext : rt_data;

	assign lt = $signed(rs_data) < $signed(op_b);

	//////////////////////////////////////////////////
	// operations
	//////////////////////////////////////////////////

	always_comb
	begin
		case (alu_op)
			// wraps, no overflow trap
			alu_add: alu_result = rs_data + op_b;
			alu_sub: alu_result = rs_data - op_b;
			alu_and: alu_result = rs_data & op_b;
			alu_or:  alu_result = rs_data | op_b;
			alu_slt: alu_result = {31'd0, lt};
			// low half of the immediate to the top
			alu_lui: alu_result = {op_b[15:0], 16'd0};
			default: alu_result = 32'd0;
		endcase
	end

	// branch compare
	// always on the two register reads
	assign zero = (rs_data == rt_data);

endmodule

//--- pc_sequencer.sv
module pc_sequencer
(
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         run,
	input  logic                         branch_eq,
	input  logic                         branch_ne,
	input  logic                         zero,
	input  logic                         jump,
	input  logic [mips_pkg::IMEM_AW-1:0] jump_index,
	input  logic [31:0]                  imm_ext,
	output logic [mips_pkg::IMEM_AW-1:0] pc_index,
	output logic                         halted
);

	import mips_pkg::*;

	logic [IMEM_AW-1:0] pc_plus1;
	logic [IMEM_AW-1:0] pc_branch;
	logic [IMEM_AW-1:0] pc_next;
	logic taken;

	//////////////////////////////////////////////////
	// next pc
	//////////////////////////////////////////////////

	// word index math wraps at IMEM_DEPTH
	assign pc_plus1 = pc_index + 1'b1;
	// offset counted from the following word
	assign pc_branch = pc_plus1 + imm_ext[IMEM_AW-1:0];

	assign taken = (branch_eq & zero) | (branch_ne & ~zero);

	// jump wins, then branch, else step
	assign pc_next = jump ? jump_index : (taken ? pc_branch : pc_plus1);

	// jump to itself means halt
	// pc_next equals pc so it holds on its own
	assign halted = jump & (jump_index == pc_index);

	//////////////////////////////////////////////////
	// pc register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pc_index <= '0;
		end
		else if (run)
		begin
			pc_index <= pc_next;
		end
	end

endmodule

//--- mem_result.sv
module mem_result
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  mem_write,
	input  logic [31:0]           alu_result,
	input  logic [31:0]           rt_data,
	input  mips_pkg::result_sel_e result_sel,
	output logic [31:0]           wb_data
);

	import mips_pkg::*;

	// data words
	logic [31:0] dmem [DMEM_DEPTH];
	// word index from the byte address
	logic [DMEM_AW-1:0] word_addr;
	logic [31:0] load_data;

	//////////////////////////////////////////////////
	// data memory
	//////////////////////////////////////////////////

	// drop byte offset, upper bits wrap
	assign word_addr = alu_result[DMEM_AW+1:2];

	// cleared so an unwritten word loads zero
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < DMEM_DEPTH; i++)
			begin
				dmem[i] <= 32'd0;
			end
		end
		else if (mem_write)
		begin
			dmem[word_addr] <= rt_data;
		end
	end

	// combinational load
	assign load_data = dmem[word_addr];

	//////////////////////////////////////////////////
	// writeback select
	//////////////////////////////////////////////////

	always_comb
	begin
		case (result_sel)
			res_load: wb_data = load_data;
			default:  wb_data = alu_result;
		endcase
	end

endmodule

//--- mips_core.sv
module mips_core
(
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         run,
	input  logic                         prog_we,
	input  logic [mips_pkg::IMEM_AW-1:0] prog_addr,
	input  logic [31:0]                  prog_data,
	output logic [mips_pkg::IMEM_AW-1:0] pc,
	output logic                         halted,
	output logic                         wb_en,
	output logic [4:0]                   wb_addr,
	output logic [31:0]                  wb_data,
	output logic                         st_en,
	output logic [mips_pkg::DMEM_AW-1:0] st_addr,
	output logic [31:0]                  st_data
);

	import mips_pkg::*;

	// fetch
	logic [IMEM_AW-1:0] pc_index;
	logic [31:0] instr;
	// decode
	logic [4:0] rs_addr;
	logic [4:0] rt_addr;
	logic [4:0] wr_addr;
	logic [31:0] imm_ext;
	logic [IMEM_AW-1:0] jump_index;
	alu_op_e alu_op;
	logic alu_use_imm;
	logic reg_write;
	logic mem_write;
	result_sel_e result_sel;
	logic branch_eq;
	logic branch_ne;
	logic jump;
	// register reads
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	// execute and writeback
	logic [31:0] alu_result;
	logic zero;
	logic [31:0] wr_data;

	//////////////////////////////////////////////////
	// fetch and decode
	//////////////////////////////////////////////////

	instr_mem instr_mem_i
	(
		.clk       (clk),
		.pc_index  (pc_index),
		.instr     (instr),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data)
	);

	instr_decode instr_decode_i
	(
		.instr       (instr),
		.run         (run),
		.rs_addr     (rs_addr),
		.rt_addr     (rt_addr),
		.wb_addr     (wr_addr),
		.imm_ext     (imm_ext),
		.jump_index  (jump_index),
		.alu_op      (alu_op),
		.alu_use_imm (alu_use_imm),
		.reg_write   (reg_write),
		.mem_write   (mem_write),
		.result_sel  (result_sel),
		.branch_eq   (branch_eq),
		.branch_ne   (branch_ne),
		.jump        (jump)
	);

	reg_file reg_file_i
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.rs_addr (rs_addr),
		.rt_addr (rt_addr),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.wr_en   (reg_write),
		.wr_addr (wr_addr),
		.wr_data (wr_data)
	);

	//////////////////////////////////////////////////
	// execute, memory, next pc
	//////////////////////////////////////////////////

	alu_execute alu_execute_i
	(
		.rs_data     (rs_data),
		.rt_data     (rt_data),
		.imm_ext     (imm_ext),
		.alu_op      (alu_op),
		.alu_use_imm (alu_use_imm),
		.alu_result  (alu_result),
		.zero        (zero)
	);

	mem_result mem_result_i
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.mem_write  (mem_write),
		.alu_result (alu_result),
		.rt_data    (rt_data),
		.result_sel (result_sel),
		.wb_data    (wr_data)
	);

	pc_sequencer pc_sequencer_i
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.run        (run),
		.branch_eq  (branch_eq),
		.branch_ne  (branch_ne),
		.zero       (zero),
		.jump       (jump),
		.jump_index (jump_index),
		.imm_ext    (imm_ext),
		.pc_index   (pc_index),
		.halted     (halted)
	);

	//////////////////////////////////////////////////
	// trace
	//////////////////////////////////////////////////

	// valid during the instruction's own cycle
	assign pc = pc_index;
	assign wb_en = reg_write;
	assign wb_addr = wr_addr;
	assign wb_data = wr_data;
	assign st_en = mem_write;
	// same word index the data memory uses
	assign st_addr = alu_result[DMEM_AW+1:2];
	assign st_data = rt_data;

endmodule

//--- tb_mips_model.sv
module tb_mips_model;

	timeunit 1ns;
	timeprecision 1ps;

	import mips_pkg::*;

	localparam int MAX_EVENTS = 64;

	// random source, fixed start
	integer seed = 82;

	// program image handed to the load port
	logic [31:0] prog [IMEM_DEPTH];

	// expected trace in retire order
	// ev_store low means register write
	bit          ev_store [MAX_EVENTS];
	logic [4:0]  ev_addr [MAX_EVENTS];
	logic [31:0] ev_data [MAX_EVENTS];
	int          ev_count;
	logic [IMEM_AW-1:0] final_pc;

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return r % n;
	endfunction

	function automatic logic [31:0] enc_r(input int rs, input int rt, input int rd,
		input funct_e fn);
		return {op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic logic [31:0] enc_i(input opcode_e op, input int rs, input int rt,
		input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	task automatic add_event(input bit is_store, input logic [4:0] addr,
		input logic [31:0] data);
		ev_store[ev_count] = is_store;
		ev_addr[ev_count] = addr;
		ev_data[ev_count] = data;
		ev_count++;
	endtask

	//////////////////////////////////////////////////
	// program generation
	//////////////////////////////////////////////////

	task automatic make_program();
		int len;
		int rs;
		int rt;
		int rd;
		int span;
		logic [15:0] imm;
		// 8 to 24 words, the last one is the halt
		len = 8 + rand_below(17);
		// every unused word and the last word jump to themselves
		for (int a = 0; a < IMEM_DEPTH; a++)
		begin
			prog[a] = {op_j, 26'(a)};
		end
		for (int i = 0; i < len - 1; i++)
		begin
			// few registers, so results get reused
			rs = rand_below(8);
			rt = rand_below(8);
			rd = rand_below(8);
			imm = 16'($random(seed));
			// words left between here and the halt
			span = len - 2 - i;
			case (rand_below(14))
				0: prog[i] = enc_r(rs, rt, rd, fn_addu);
				1: prog[i] = enc_r(rs, rt, rd, fn_subu);
				2: prog[i] = enc_r(rs, rt, rd, fn_and);
				3: prog[i] = enc_r(rs, rt, rd, fn_or);
				4: prog[i] = enc_r(rs, rt, rd, fn_slt);
				5: prog[i] = enc_i(op_addiu, rs, rt, imm);
				6: prog[i] = enc_i(op_andi, rs, rt, imm);
				7: prog[i] = enc_i(op_ori, rs, rt, imm);
				8: prog[i] = enc_i(op_lui, 0, rt, imm);
				// small word offsets off r0
				9: prog[i] = enc_i(op_lw, 0, rt, 16'(4 * rand_below(6)));
				10: prog[i] = enc_i(op_sw, 0, rt, 16'(4 * rand_below(6)));
				// forward only, never past the halt word
				11: prog[i] = enc_i(op_beq, rs, rt, 16'(rand_below((span < 3 ? span : 3) + 1)));
				12: prog[i] = enc_i(op_bne, rs, rt, 16'(rand_below((span < 3 ? span : 3) + 1)));
				default: prog[i] = {op_j, 26'(i + 1 + rand_below(span + 1))};
			endcase
		end
	endtask

	//////////////////////////////////////////////////
	// reference execution
	//////////////////////////////////////////////////

	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] dmem [DMEM_DEPTH];
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sx;
		logic [31:0] zx;
		logic [31:0] res;
		logic [31:0] word;
		logic [4:0] dest;
		logic [IMEM_AW-1:0] pc;
		logic [IMEM_AW-1:0] pc_next;
		bit wr;
		bit done;
		int steps;
		// state as after reset
		for (int i = 0; i < 32; i++)
		begin
			regs[i] = 32'd0;
		end
		for (int i = 0; i < DMEM_DEPTH; i++)
		begin
			dmem[i] = 32'd0;
		end
		pc = '0;
		final_pc = '0;
		ev_count = 0;
		done = 0;
		steps = 0;
		while (!done && steps < 200)
		begin
			ins = prog[pc];
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			sx = {{16{ins[15]}}, ins[15:0]};
			zx = {16'd0, ins[15:0]};
			word = (a + sx) >> 2;
			res = 32'd0;
			dest = ins[20:16];
			wr = 1;
			pc_next = pc + 5'd1;
			case (opcode_e'(ins[31:26]))
				op_rtype:
				begin
					dest = ins[15:11];
					case (funct_e'(ins[5:0]))
						fn_addu: res = a + b;
						fn_subu: res = a - b;
						fn_and:  res = a & b;
						fn_or:   res = a | b;
						fn_slt:  res = {31'd0, $signed(a) < $signed(b)};
						default: wr = 0;
					endcase
				end
				op_addiu: res = a + sx;
				op_andi:  res = a & zx;
				op_ori:   res = a | zx;
				op_lui:   res = {ins[15:0], 16'd0};
				op_lw:    res = dmem[word % DMEM_DEPTH];
				op_sw:
				begin
					wr = 0;
					add_event(1, 5'(word % DMEM_DEPTH), b);
					dmem[word % DMEM_DEPTH] = b;
				end
				op_beq:
				begin
					wr = 0;
					if (a == b)
						pc_next = pc + 5'd1 + sx[IMEM_AW-1:0];
				end
				op_bne:
				begin
					wr = 0;
					if (a != b)
						pc_next = pc + 5'd1 + sx[IMEM_AW-1:0];
				end
				op_j:
				begin
					wr = 0;
					pc_next = ins[IMEM_AW-1:0];
					// jump onto itself ends the program
					if (pc_next == pc)
					begin
						done = 1;
						final_pc = pc;
					end
				end
				default: wr = 0;
			endcase
			// r0 stays zero and leaves no trace
			if (wr && dest != 5'd0)
			begin
				regs[dest] = res;
				add_event(0, dest, res);
			end
			pc = pc_next;
			steps++;
		end
	endtask

endmodule

//--- tb_mips_core.sv
module tb_mips_core;

	timeunit 1ns;
	timeprecision 1ps;

	import mips_pkg::*;

	localparam int PROGRAMS = 20;
	localparam int HALT_TIMEOUT = 200;

	logic clk;
	logic rst_n;
	logic run;
	logic prog_we;
	logic [IMEM_AW-1:0] prog_addr;
	logic [31:0] prog_data;
	logic [IMEM_AW-1:0] pc;
	logic halted;
	logic wb_en;
	logic [4:0] wb_addr;
	logic [31:0] wb_data;
	logic st_en;
	logic [DMEM_AW-1:0] st_addr;
	logic [31:0] st_data;

	int value_errors;
	int other_errors;
	// next expected trace event
	int ev_idx;

	mips_core mips_core_i
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.run       (run),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.pc        (pc),
		.halted    (halted),
		.wb_en     (wb_en),
		.wb_addr   (wb_addr),
		.wb_data   (wb_data),
		.st_en     (st_en),
		.st_addr   (st_addr),
		.st_data   (st_data)
	);

	// random programs and their expected traces
	tb_mips_model model_i ();

	// 10 ns period
	always #5 clk = ~clk;

	//////////////////////////////////////////////////
	// reporting
	//////////////////////////////////////////////////

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("FAIL time %0t: %s expected 0x%08h actual 0x%08h",
			$time, name, expected, actual);
		value_errors++;
	endtask

	task automatic report_problem(input string what);
		$display("ERROR at time %0t: %s", $time, what);
		other_errors++;
	endtask

	// stopped core retires nothing
	// word 0 is never a halt jump
	task automatic check_idle();
		if (wb_en !== 1'b0)
			report_problem("register write while the core is stopped");
		if (st_en !== 1'b0)
			report_problem("store while the core is stopped");
		if (halted !== 1'b0)
			report_problem("halted high while the core is stopped at word 0");
		if (pc !== '0)
			report_mismatch("pc", 32'd0, 32'(pc));
	endtask

	//////////////////////////////////////////////////
	// trace compare
	//////////////////////////////////////////////////

	task automatic check_trace();
		if (wb_en === 1'b1)
		begin
			if (wb_addr == 5'd0)
				report_problem("register write to r0 shown on the trace");
			if (ev_idx >= model_i.ev_count)
				report_problem("register write after the last expected event");
			else
			begin
				if (model_i.ev_store[ev_idx])
					report_problem("register write where a store was expected");
				else
				begin
					if (wb_addr !== model_i.ev_addr[ev_idx])
						report_mismatch("wb_addr", 32'(model_i.ev_addr[ev_idx]), 32'(wb_addr));
					if (wb_data !== model_i.ev_data[ev_idx])
						report_mismatch("wb_data", model_i.ev_data[ev_idx], wb_data);
				end
				ev_idx++;
			end
		end
		if (st_en === 1'b1)
		begin
			if (ev_idx >= model_i.ev_count)
				report_problem("store after the last expected event");
			else
			begin
				if (!model_i.ev_store[ev_idx])
					report_problem("store where a register write was expected");
				else
				begin
					if (32'(st_addr) !== 32'(model_i.ev_addr[ev_idx]))
						report_mismatch("st_addr", 32'(model_i.ev_addr[ev_idx]), 32'(st_addr));
					if (st_data !== model_i.ev_data[ev_idx])
						report_mismatch("st_data", model_i.ev_data[ev_idx], st_data);
				end
				ev_idx++;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// test phases
	//////////////////////////////////////////////////

	task automatic apply_reset();
		@(negedge clk);
		rst_n = 1'b0;
		run = 1'b0;
		prog_we = 1'b0;
		repeat (16) @(negedge clk);
		check_idle();
		rst_n = 1'b1;
	endtask

	// whole store written
	// unused words hold halt jumps
	task automatic load_program();
		for (int a = 0; a < IMEM_DEPTH; a++)
		begin
			@(negedge clk);
			check_idle();
			prog_we = 1'b1;
			prog_addr = IMEM_AW'(a);
			prog_data = model_i.prog[a];
		end
		@(negedge clk);
		prog_we = 1'b0;
		check_idle();
	endtask

	task automatic run_program();
		int cycles;
		bit stopped;
		ev_idx = 0;
		cycles = 0;
		stopped = 0;
		@(negedge clk);
		run = 1'b1;
		while (!stopped && cycles < HALT_TIMEOUT)
		begin
			// 1 ns before the rising edge
			#4;
			check_trace();
			if (halted === 1'b1)
			begin
				stopped = 1;
				if (pc !== model_i.final_pc)
					report_mismatch("pc", 32'(model_i.final_pc), 32'(pc));
				if (ev_idx != model_i.ev_count)
					report_problem("halted before all expected trace events appeared");
			end
			// halt word is the only way to reach final_pc
			else if (pc === model_i.final_pc)
			begin
				stopped = 1;
				report_problem("halt jump fetched without raising halted");
			end
			@(negedge clk);
			cycles++;
		end
		run = 1'b0;
		if (!stopped)
			report_problem("timeout waiting for halted");
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		run = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = 32'd0;
		value_errors = 0;
		other_errors = 0;
		ev_idx = 0;
		for (int p = 0; p < PROGRAMS; p++)
		begin
			apply_reset();
			// expected trace ready before the core runs
			model_i.make_program();
			model_i.run_model();
			load_program();
			run_program();
		end
		$display("errors: %0d value mismatches, %0d other failures",
			value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- sources.f
mips_pkg.sv
instr_mem.sv
instr_decode.sv
reg_file.sv
alu_execute.sv
pc_sequencer.sv
mem_result.sv
mips_core.sv
tb_mips_model.sv
tb_mips_core.sv
